// File: build.f
logic/cpu_pkg.sv
logic/instr_decode.sv
logic/alu_execute.sv
logic/result_writeback.sv
logic/seq_control.sv
logic/cpu_core.sv
sim/tb_memory.sv
sim/cpu_tb.sv

// File: sim/cpu_tb.sv
`default_nettype none

module cpu_tb;

    localparam int seed = 1;
    localparam int max_prog_len = 64;
    localparam int timeout_cycles = max_prog_len * 3 + 50;
    localparam int num_tests = 6;

    logic        clock;
    logic        rst_n;
    logic [31:0] data_in;
    logic [31:0] data_out;
    logic [31:0] address;
    logic        rw;

    // memory contents at reset, program at the bottom
    logic [31:0] image [256];
    int          prog_len;
    int          test_start [num_tests + 1];
    string       test_name [num_tests];

    logic [31:0] model_regs [8];
    logic [7:0]  model_flags;
    logic [31:0] model_mem [256];
    logic [31:0] model_pc;
    logic [31:0] next_pc;
    int          phase;

    logic [31:0] exp_address;
    logic        exp_rw;
    logic        exp_store;
    logic [31:0] exp_data_out;
    logic [31:0] exec_address;
    logic        exec_rw;
    logic        exec_store;
    logic [31:0] exec_data;

    int cur_test = 0;
    int test_errors = 0;
    int error_count = 0;
    int pass_tests = 0;
    int fail_tests = 0;
    bit done = 1'b0;

    cpu_core cpu_core_i (
        .clock(clock), .rst_n(rst_n), .data_in(data_in),
        .data_out(data_out), .address(address), .rw(rw)
    );

    tb_memory memory_i (
        .clock(clock), .address(address), .write_data(data_out),
        .rw(rw), .read_data(data_in)
    );

    function automatic logic [31:0] fill_word(input int addr);
        logic [7:0] a;
        a = addr[7:0];
        return {a, ~a, a ^ 8'h5a, 8'hc3};
    endfunction

    function automatic logic [31:0] encode(input logic [5:0] op, input int a, input int b,
                                           input int d, input logic hi, input logic [15:0] imm);
        return {imm, hi, d[2:0], b[2:0], a[2:0], op};
    endfunction

    task automatic emit(input logic [31:0] word);
        image[prog_len] = word;
        prog_len++;
    endtask

    // full 32-bit constant in two loadi steps
    task automatic set_reg(input int r, input logic [31:0] value);
        emit(encode(cpu_pkg::op_loadi, r, 0, r, 1'b1, value[31:16]));
        emit(encode(cpu_pkg::op_loadi, r, 0, r, 1'b0, value[15:0]));
    endtask

    // a set flag skips the nop behind the branch
    task automatic flag_branch(input int r);
        emit(encode(cpu_pkg::op_branch, r, 0, 0, 1'b0, 16'(prog_len + 2)));
        emit(encode(cpu_pkg::op_nop, 0, 0, 0, 1'b0, 16'h0));
    endtask

    task automatic alu_case(input logic [5:0] op, input bit check_flag);
        emit(encode(op, 1, 2, 3, 1'b0, 16'h0));
        emit(encode(cpu_pkg::op_store, 3, 7, 0, 1'b0, 16'h0));
        if (check_flag)
        begin
            flag_branch(3);
        end
    endtask

    task automatic begin_test(input int idx, input string name);
        test_start[idx] = prog_len;
        test_name[idx] = name;
    endtask

    task automatic build_program();
        logic [31:0] v1;
        logic [31:0] v2;
        logic [15:0] imm_lo;
        logic [15:0] imm_hi;
        v1 = $urandom();
        v2 = $urandom();
        if (v2 == v1)
        begin
            v2 = v2 ^ 32'h1;
        end
        imm_lo = 16'($urandom());
        imm_hi = 16'($urandom());
        for (int i = 0; i < 256; i++)
        begin
            image[i] = fill_word(i);
        end
        prog_len = 0;
        begin_test(0, "fetch sequence");
        repeat (4) emit(encode(cpu_pkg::op_nop, 0, 0, 0, 1'b0, 16'h0));
        begin_test(1, "alu operations");
        set_reg(1, v1);
        set_reg(2, v2);
        set_reg(7, 32'd128);
        alu_case(cpu_pkg::op_add, 1'b1);
        alu_case(cpu_pkg::op_sub, 1'b1);
        alu_case(cpu_pkg::op_and, 1'b0);
        alu_case(cpu_pkg::op_or, 1'b0);
        alu_case(cpu_pkg::op_xor, 1'b0);
        begin_test(2, "loadi halves");
        emit(encode(cpu_pkg::op_loadi, 1, 0, 4, 1'b0, imm_lo));
        emit(encode(cpu_pkg::op_store, 4, 7, 0, 1'b0, 16'h0));
        emit(encode(cpu_pkg::op_loadi, 2, 0, 4, 1'b1, imm_hi));
        emit(encode(cpu_pkg::op_store, 4, 7, 0, 1'b0, 16'h0));
        begin_test(3, "compare and branch");
        emit(encode(cpu_pkg::op_cmp, 1, 2, 5, 1'b0, 16'h0));
        emit(encode(cpu_pkg::op_store, 5, 7, 0, 1'b0, 16'h0));
        flag_branch(5);
        emit(encode(cpu_pkg::op_cmp, 2, 1, 6, 1'b0, 16'h0));
        emit(encode(cpu_pkg::op_store, 6, 7, 0, 1'b0, 16'h0));
        flag_branch(6);
        begin_test(4, "jump");
        emit(encode(cpu_pkg::op_jump, 0, 0, 0, 1'b0, 16'(prog_len + 3)));
        repeat (3) emit(encode(cpu_pkg::op_nop, 0, 0, 0, 1'b0, 16'h0));
        begin_test(5, "load and store");
        set_reg(6, 32'd200);
        set_reg(7, 32'd201);
        emit(encode(cpu_pkg::op_load, 0, 6, 5, 1'b0, 16'h0));
        emit(encode(cpu_pkg::op_store, 5, 7, 0, 1'b0, 16'h0));
        // program ends in a jump to itself
        test_start[num_tests] = prog_len;
        emit(encode(cpu_pkg::op_jump, 0, 0, 0, 1'b0, 16'(prog_len)));
    endtask

    task automatic reset_model();
        for (int i = 0; i < 8; i++)
        begin
            model_regs[i] = 32'd15;
        end
        model_flags = '0;
        model_mem = image;
        model_pc = '0;
        phase = 0;
    endtask

    // whole instruction at once, execute-cycle bus values kept for later
    task automatic step_instruction();
        logic [31:0] instr;
        logic [31:0] ra;
        logic [31:0] rb;
        logic [31:0] res;
        logic [32:0] wide;
        logic        flag;
        logic        writes;
        instr = model_mem[model_pc[7:0]];
        ra = model_regs[instr[8:6]];
        rb = model_regs[instr[11:9]];
        res = '0;
        flag = 1'b0;
        writes = 1'b1;
        exec_address = model_pc;
        exec_rw = 1'b1;
        exec_store = 1'b0;
        exec_data = ra;
        next_pc = model_pc + 1;
        case (instr[5:0])
            cpu_pkg::op_add:
            begin
                wide = {1'b0, ra} + {1'b0, rb};
                res = wide[31:0];
                flag = wide[32];
            end
            cpu_pkg::op_sub:
            begin
                wide = {1'b0, ra} - {1'b0, rb};
                res = wide[31:0];
                flag = wide[32];
            end
            cpu_pkg::op_and: res = ra & rb;
            cpu_pkg::op_or:  res = ra | rb;
            cpu_pkg::op_xor: res = ra ^ rb;
            cpu_pkg::op_loadi:
            begin
                res = instr[15] ? {instr[31:16], ra[15:0]} : {ra[31:16], instr[31:16]};
            end
            cpu_pkg::op_store:
            begin
                writes = 1'b0;
                exec_address = rb;
                exec_rw = 1'b0;
                exec_store = 1'b1;
                model_mem[rb[7:0]] = ra;
            end
            cpu_pkg::op_load:
            begin
                exec_address = rb;
                res = model_mem[rb[7:0]];
            end
            cpu_pkg::op_cmp:
            begin
                flag = ra < rb;
                res = {31'b0, flag};
            end
            cpu_pkg::op_jump:
            begin
                writes = 1'b0;
                next_pc = {16'h0, instr[31:16]};
            end
            cpu_pkg::op_branch:
            begin
                writes = 1'b0;
                if (model_flags[instr[8:6]])
                begin
                    next_pc = {16'h0, instr[31:16]};
                end
            end
            default: writes = 1'b0;
        endcase
        if (writes)
        begin
            model_regs[instr[14:12]] = res;
            model_flags[instr[14:12]] = flag;
        end
    endtask

    task automatic enter_fetch();
        exp_address = model_pc;
        exp_rw = 1'b1;
        exp_store = 1'b0;
        step_instruction();
    endtask

    task automatic finish_test();
        if (test_errors == 0)
        begin
            pass_tests++;
            $display("test %0d %s: ok", cur_test, test_name[cur_test]);
        end
        else
        begin
            fail_tests++;
            $display("test %0d %s: %0d errors", cur_test, test_name[cur_test], test_errors);
        end
        test_errors = 0;
        cur_test++;
        if (cur_test == num_tests)
        begin
            done = 1'b1;
        end
    endtask

    task automatic value_fail(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        error_count++;
        test_errors++;
        $display("Fail t=%0t %s expected %h got %h", $time, name, expected, actual);
    endtask

    // reference model, three cycles per instruction counted from reset
    always @(posedge clock)
    begin
        if (!rst_n)
        begin
            reset_model();
            enter_fetch();
        end
        else
        begin
            phase = (phase + 1) % 3;
            if (phase == 0)
            begin
                enter_fetch();
            end
            else if (phase == 1)
            begin
                exp_address = exec_address;
                exp_rw = exec_rw;
                exp_store = exec_store;
                exp_data_out = exec_data;
            end
            else
            begin
                exp_address = model_pc;
                exp_rw = 1'b1;
                exp_store = 1'b0;
                // a test is done once the next test's first fetch has been checked
                if (cur_test < num_tests && model_pc == test_start[cur_test + 1])
                begin
                    finish_test();
                end
                model_pc = next_pc;
            end
        end
    end

    check_address: assert property (@(posedge clock) disable iff (!rst_n)
        address == exp_address)
        else value_fail("address", $sampled(exp_address), $sampled(address));

    check_rw: assert property (@(posedge clock) disable iff (!rst_n)
        rw == exp_rw)
        else value_fail("rw", 32'($sampled(exp_rw)), 32'($sampled(rw)));

    check_data_out: assert property (@(posedge clock) disable iff (!rst_n)
        exp_store |-> data_out == exp_data_out)
        else value_fail("data_out", $sampled(exp_data_out), $sampled(data_out));

    initial
    begin
        clock = 1'b0;
        forever #20 clock = ~clock;
    end

    initial
    begin
        repeat (timeout_cycles) @(posedge clock);
        $display("watchdog: program did not reach its end within %0d cycles", timeout_cycles);
        $display("Regression failed");
        $finish;
    end

    initial
    begin
        void'($urandom(seed));
        rst_n = 1'b0;
        build_program();
        for (int i = 0; i < 256; i++)
        begin
            memory_i.words[i] = image[i];
        end
        repeat (10) @(negedge clock);
        rst_n = 1'b1;
        wait (done);
        @(negedge clock);
        $display("%0d tests passed, %0d tests failed, %0d check errors",
                 pass_tests, fail_tests, error_count);
        if (fail_tests == 0 && error_count == 0)
        begin
            $display("Regression passed");
        end
        else
        begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: sim/tb_memory.sv
`default_nettype none

module tb_memory (
    input  wire                              clock,
    input  wire  [cpu_pkg::data_width-1:0]   address,
    input  wire  [cpu_pkg::data_width-1:0]   write_data,
    input  wire                              rw,
    output logic [cpu_pkg::data_width-1:0]   read_data
);

    localparam int depth = 256;

    logic [cpu_pkg::data_width-1:0] words [depth];

    // only the low byte of the address selects a word
    assign read_data = words[address[7:0]];

    // write at the clock edge while rw is low
    always @(posedge clock)
    begin
        if (rw === 1'b0)
        begin
            words[address[7:0]] <= write_data;
        end
    end

endmodule

`default_nettype wire

// File: logic/cpu_core.sv
`default_nettype none

module cpu_core (
    input  wire                                 clock,
    input  wire                                 rst_n,
    input  wire  [cpu_pkg::data_width-1:0]      data_in,
    output logic [cpu_pkg::data_width-1:0]      data_out,
    output logic [cpu_pkg::data_width-1:0]      address,
    output logic                                rw
);

    cpu_pkg::state_t                    state;
    cpu_pkg::opcode_t                   op;
    logic [cpu_pkg::reg_addr_width-1:0] src_a;
    logic [cpu_pkg::reg_addr_width-1:0] src_b;
    logic [cpu_pkg::reg_addr_width-1:0] dest;
    logic                               high_half;
    logic [cpu_pkg::imm_width-1:0]      imm;
    logic [cpu_pkg::data_width-1:0]     value_a;
    logic [cpu_pkg::data_width-1:0]     value_b;
    logic                               flag_a;
    logic [cpu_pkg::data_width-1:0]     result;
    logic                               flag_result;
    logic                               reg_write;
    logic                               mem_write;
    logic                               take_branch;

    instr_decode instr_decode_i (
        .clock(clock), .rst_n(rst_n), .state(state), .data_in(data_in),
        .op(op), .src_a(src_a), .src_b(src_b), .dest(dest),
        .high_half(high_half), .imm(imm)
    );

    // memory read data doubles as the load result
    alu_execute alu_execute_i (
        .state(state), .op(op), .high_half(high_half), .imm(imm),
        .value_a(value_a), .value_b(value_b), .flag_a(flag_a), .mem_rdata(data_in),
        .result(result), .flag_result(flag_result), .reg_write(reg_write),
        .mem_write(mem_write), .take_branch(take_branch)
    );

    result_writeback result_writeback_i (
        .clock(clock), .rst_n(rst_n), .src_a(src_a), .src_b(src_b), .dest(dest),
        .reg_write(reg_write), .result(result), .flag_result(flag_result),
        .value_a(value_a), .value_b(value_b), .flag_a(flag_a)
    );

    seq_control seq_control_i (
        .clock(clock), .rst_n(rst_n), .take_branch(take_branch),
        .mem_write(mem_write), .op(op), .imm(imm), .value_b(value_b),
        .state(state), .address(address), .rw(rw)
    );

    // store data is always source A
    assign data_out = value_a;

endmodule

`default_nettype wire

// File: logic/seq_control.sv
`default_nettype none

module seq_control (
    input  wire                                   clock,
    input  wire                                   rst_n,
    input  wire                                   take_branch,
    input  wire                                   mem_write,
    input  cpu_pkg::opcode_t                      op,
    input  wire        [cpu_pkg::imm_width-1:0]   imm,
    input  wire        [cpu_pkg::data_width-1:0]  value_b,
    output cpu_pkg::state_t                       state,
    output logic       [cpu_pkg::data_width-1:0]  address,
    output logic                                  rw
);

    cpu_pkg::state_t                state_next;
    logic [cpu_pkg::data_width-1:0] pc;
    logic [cpu_pkg::data_width-1:0] branch_target;
    logic                           mem_access;

    always_comb
    begin
        case (state)
            cpu_pkg::st_fetch:   state_next = cpu_pkg::st_execute;
            cpu_pkg::st_execute: state_next = cpu_pkg::st_advance;
            default:             state_next = cpu_pkg::st_fetch;
        endcase
    end

    always_ff @(posedge clock)
    begin
        if (!rst_n)
        begin
            state <= cpu_pkg::st_fetch;
        end
        else
        begin
            state <= state_next;
        end
    end

    // jump and branch targets are the zero-extended immediate
    assign branch_target = {{(cpu_pkg::data_width-cpu_pkg::imm_width){1'b0}}, imm};

    always_ff @(posedge clock)
    begin
        if (!rst_n)
        begin
            pc <= cpu_pkg::pc_reset_value;
        end
        else if (state == cpu_pkg::st_advance)
        begin
            pc <= take_branch ? branch_target : pc + 1'b1;
        end
    end

    // load and store borrow the bus for one execute cycle
    assign mem_access = (state == cpu_pkg::st_execute) &&
                        ((op == cpu_pkg::op_load) || (op == cpu_pkg::op_store));

    assign address = mem_access ? value_b : pc;
    assign rw      = !mem_write;

    assert property (@(posedge clock) disable iff (!rst_n)
        state inside {cpu_pkg::st_fetch, cpu_pkg::st_execute, cpu_pkg::st_advance})
        else $error("illegal sequencer state");

    assert property (@(posedge clock) disable iff (!rst_n)
        !rw |-> state == cpu_pkg::st_execute)
        else $error("bus write outside execute");

endmodule

`default_nettype wire

// File: logic/result_writeback.sv
`default_nettype none

module result_writeback (
    input  wire                                      clock,
    input  wire                                      rst_n,
    input  wire  [cpu_pkg::reg_addr_width-1:0]       src_a,
    input  wire  [cpu_pkg::reg_addr_width-1:0]       src_b,
    input  wire  [cpu_pkg::reg_addr_width-1:0]       dest,
    input  wire                                      reg_write,
    input  wire  [cpu_pkg::data_width-1:0]           result,
    input  wire                                      flag_result,
    output logic [cpu_pkg::data_width-1:0]           value_a,
    output logic [cpu_pkg::data_width-1:0]           value_b,
    output logic                                     flag_a
);

    logic [cpu_pkg::data_width-1:0] regs [cpu_pkg::reg_count];
    logic [cpu_pkg::reg_count-1:0]  flags;

    // register file
    always_ff @(posedge clock)
    begin
        if (!rst_n)
        begin
            for (int i = 0; i < cpu_pkg::reg_count; i++)
            begin
                regs[i] <= cpu_pkg::reg_reset_value;
            end
        end
        else if (reg_write)
        begin
            regs[dest] <= result;
        end
    end

    // flag bits, written alongside the register
    always_ff @(posedge clock)
    begin
        if (!rst_n)
        begin
            flags <= '0;
        end
        else if (reg_write)
        begin
            flags[dest] <= flag_result;
        end
    end

    // read ports
    assign value_a = regs[src_a];
    assign value_b = regs[src_b];
    assign flag_a  = flags[src_a];

    // sequencer must start in fetch, so nothing commits right after reset
    assert property (@(posedge clock) $rose(rst_n) |-> !reg_write)
        else $error("register write in first cycle after reset");

endmodule

`default_nettype wire

// File: logic/alu_execute.sv
`default_nettype none

module alu_execute (
    input  cpu_pkg::state_t                      state,
    input  cpu_pkg::opcode_t                     op,
    input  wire                                  high_half,
    input  wire        [cpu_pkg::imm_width-1:0]  imm,
    input  wire        [cpu_pkg::data_width-1:0] value_a,
    input  wire        [cpu_pkg::data_width-1:0] value_b,
    input  wire                                  flag_a,
    input  wire        [cpu_pkg::data_width-1:0] mem_rdata,
    output logic       [cpu_pkg::data_width-1:0] result,
    output logic                                 flag_result,
    output logic                                 reg_write,
    output logic                                 mem_write,
    output logic                                 take_branch
);

    logic [cpu_pkg::data_width:0] sum;
    logic [cpu_pkg::data_width:0] diff;
    logic                         less_than;
    logic                         writes_reg;
    logic                         branch_hit;
    logic                         in_execute;

    // one extra bit holds carry out and borrow
    assign sum  = {1'b0, value_a} + {1'b0, value_b};
    assign diff = {1'b0, value_a} - {1'b0, value_b};
    assign less_than = value_a < value_b;

    assign in_execute = state == cpu_pkg::st_execute;

    always_comb
    begin
        result      = '0;
        flag_result = 1'b0;
        writes_reg  = 1'b1;
        case (op)
            cpu_pkg::op_add:
            begin
                result      = sum[cpu_pkg::data_width-1:0];
                flag_result = sum[cpu_pkg::data_width];
            end
            cpu_pkg::op_sub:
            begin
                result      = diff[cpu_pkg::data_width-1:0];
                flag_result = diff[cpu_pkg::data_width];
            end
            cpu_pkg::op_and: result = value_a & value_b;
            cpu_pkg::op_or:  result = value_a | value_b;
            cpu_pkg::op_xor: result = value_a ^ value_b;
            cpu_pkg::op_loadi:
            begin
                // the half not loaded comes from source A
                if (high_half)
                begin
                    result = {imm, value_a[15:0]};
                end
                else
                begin
                    result = {value_a[31:16], imm};
                end
            end
            cpu_pkg::op_load: result = mem_rdata;
            cpu_pkg::op_cmp:
            begin
                result      = {{(cpu_pkg::data_width-1){1'b0}}, less_than};
                flag_result = less_than;
            end
            default: writes_reg = 1'b0;
        endcase
    end

    assign reg_write = in_execute && writes_reg;
    assign mem_write = in_execute && (op == cpu_pkg::op_store);

    assign branch_hit = (op == cpu_pkg::op_jump) ||
                        ((op == cpu_pkg::op_branch) && flag_a);

    // kept up through advance, where the PC takes it
    assign take_branch = branch_hit &&
                         (in_execute || (state == cpu_pkg::st_advance));

    // state moves every cycle, so its change serves as the sampling event
    assert property (@(state) !(reg_write && mem_write))
        else $error("register and memory write in the same cycle");

endmodule

`default_nettype wire

// File: logic/instr_decode.sv
`default_nettype none

module instr_decode (
    input  wire                                   clock,
    input  wire                                   rst_n,
    input  cpu_pkg::state_t                       state,
    input  wire        [cpu_pkg::data_width-1:0]  data_in,
    output cpu_pkg::opcode_t                      op,
    output logic       [cpu_pkg::reg_addr_width-1:0] src_a,
    output logic       [cpu_pkg::reg_addr_width-1:0] src_b,
    output logic       [cpu_pkg::reg_addr_width-1:0] dest,
    output logic                                  high_half,
    output logic       [cpu_pkg::imm_width-1:0]   imm
);

    logic [cpu_pkg::data_width-1:0] instr_reg;
    logic [cpu_pkg::op_width-1:0]   raw_op;

    // instruction register, only written while fetching
    always_ff @(posedge clock)
    begin
        if (!rst_n)
        begin
            // all-zero word decodes as nop
            instr_reg <= '0;
        end
        else if (state == cpu_pkg::st_fetch)
        begin
            instr_reg <= data_in;
        end
    end

    // field split
    assign raw_op    = instr_reg[5:0];
    assign src_a     = instr_reg[8:6];
    assign src_b     = instr_reg[11:9];
    assign dest      = instr_reg[14:12];
    assign high_half = instr_reg[15];
    assign imm       = instr_reg[31:16];

    // unknown codes fold to nop so downstream only sees legal values
    always_comb
    begin
        if (raw_op <= cpu_pkg::op_branch)
        begin
            op = cpu_pkg::opcode_t'(raw_op);
        end
        else
        begin
            op = cpu_pkg::op_nop;
        end
    end

endmodule

`default_nettype wire

// File: logic/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

    localparam int data_width = 32;
    localparam int reg_count = 8;
    localparam int reg_addr_width = 3;
    localparam int imm_width = 16;
    localparam int op_width = 6;

    // general registers come out of reset holding 15
    localparam logic [data_width-1:0] reg_reset_value = 32'd15;
    localparam logic [data_width-1:0] pc_reset_value = 32'd0;

    typedef enum logic [1:0] {
        st_fetch   = 2'd0,
        st_execute = 2'd1,
        st_advance = 2'd2
    } state_t;

    // codes above op_branch are decoded as nop
    typedef enum logic [op_width-1:0] {
        op_nop    = 6'd0,
        op_add    = 6'd1,
        op_sub    = 6'd2,
        op_and    = 6'd3,
        op_or     = 6'd4,
        op_xor    = 6'd5,
        op_loadi  = 6'd6,
        op_store  = 6'd7,
        op_load   = 6'd8,
        op_cmp    = 6'd9,
        op_jump   = 6'd10,
        op_branch = 6'd11
    } opcode_t;

endpackage

`default_nettype wire
